// File: hw/xcvr_mgmt_pkg.sv
/* widths, register map, reset timings and shared types of the transceiver
   management logic; compile it before every RTL and bench file */
`default_nettype none

package xcvr_mgmt_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int LANES       = 4;   // transceiver lanes
  localparam int MGMT_ADDR_W = 8;   // management word address
  localparam int MGMT_DATA_W = 32;
  localparam int TIMER_W     = 6;   // covers the longest reset period

  typedef logic [LANES-1:0]       lane_vec_t;   // one bit per lane
  typedef logic [MGMT_ADDR_W-1:0] mgmt_addr_t;
  typedef logic [MGMT_DATA_W-1:0] mgmt_data_t;
  typedef logic [TIMER_W-1:0]     rst_timer_t;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////
  localparam mgmt_addr_t ADDR_STATUS     = 8'h22;  // ro: pll_locked, tx_ready, rx_ready
  localparam mgmt_addr_t ADDR_RX_LOCK    = 8'h23;  // ro: lockedtoref [3:0], lockedtodata [11:8]
  localparam mgmt_addr_t ADDR_RESET_REQ  = 8'h42;  // wo: all, tx digital, rx digital
  localparam mgmt_addr_t ADDR_LOOPBACK   = 8'h61;  // serial loopback per lane
  localparam mgmt_addr_t ADDR_LOCKTOREF  = 8'h64;
  localparam mgmt_addr_t ADDR_LOCKTODATA = 8'h65;
  localparam mgmt_addr_t ADDR_PCS_ERR    = 8'h82;  // w1c: errdetect [3:0], disperr [11:8]
  localparam mgmt_addr_t ADDR_TX_INVPOL  = 8'h83;

  // reset periods in phy_mgmt_clk cycles (reduced simulation values)
  localparam int T_PLL_POWERDOWN   = 16;
  localparam int T_TX_DIGITALRESET = 8;   // counted from synchronized pll_locked
  localparam int T_RX_ANALOGRESET  = 8;
  localparam int T_RX_DIGITALRESET = 32;  // counted from all lanes locked to ref

  // reset sequencer states
  typedef enum logic [1:0] {TX_PLL_PD, TX_WAIT_LOCK, TX_DIG_RST, TX_READY} tx_rst_state_t;
  typedef enum logic [1:0] {RX_ANA_RST, RX_WAIT_LOCK, RX_DIG_RST, RX_READY} rx_rst_state_t;

endpackage

`default_nettype wire

// File: hw/mgmt_csr_common.sv
/* common register block; loopback and lock forcing per lane, self-clearing
   reset requests for the sequencer, PHY and sequencer status readback */
`timescale 1ns/10ps
`default_nettype none

module mgmt_csr_common (
  input  wire                            phy_mgmt_clk,
  input  wire                            arst_n,
  input  wire xcvr_mgmt_pkg::mgmt_addr_t mgmt_address,
  input  wire                            mgmt_write,
  input  wire xcvr_mgmt_pkg::mgmt_data_t mgmt_writedata,
  input  wire                            pll_locked,
  input  wire xcvr_mgmt_pkg::lane_vec_t  rx_is_lockedtoref,
  input  wire xcvr_mgmt_pkg::lane_vec_t  rx_is_lockedtodata,
  input  wire                            tx_ready,
  input  wire                            rx_ready,
  output xcvr_mgmt_pkg::mgmt_data_t      rdata_common,
  output logic                           req_reset_all,
  output logic                           req_tx_digital,
  output logic                           req_rx_digital,
  output xcvr_mgmt_pkg::lane_vec_t       rx_seriallpbken,
  output xcvr_mgmt_pkg::lane_vec_t       rx_set_locktoref,
  output xcvr_mgmt_pkg::lane_vec_t       rx_set_locktodata
);
  import xcvr_mgmt_pkg::*;

  localparam int LANE_PAD = MGMT_DATA_W - LANES;  // zero fill above the lane bits

  logic rst_req_wr;  // write strobe for the request register

  assign rst_req_wr = mgmt_write && (mgmt_address == ADDR_RESET_REQ);

  ////////////////////////////////////////////////////////////////////////////
  // read/write lane registers
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_seriallpbken   <= '0;
      rx_set_locktoref  <= '0;
      rx_set_locktodata <= '0;
    end else if (mgmt_write) begin
      case (mgmt_address)
        ADDR_LOOPBACK:   rx_seriallpbken   <= mgmt_writedata[LANES-1:0];
        ADDR_LOCKTOREF:  rx_set_locktoref  <= mgmt_writedata[LANES-1:0];
        ADDR_LOCKTODATA: rx_set_locktodata <= mgmt_writedata[LANES-1:0];
        default: ;  // other addresses belong elsewhere
      endcase
    end
  end

  // reset requests, one cycle wide, gone again by the next cycle
  always_ff @(posedge phy_mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      req_reset_all  <= 1'b0;
      req_tx_digital <= 1'b0;
      req_rx_digital <= 1'b0;
    end else begin
      req_reset_all  <= rst_req_wr & mgmt_writedata[0];  // full sequence
      req_tx_digital <= rst_req_wr & mgmt_writedata[1];  // tx pcs only
      req_rx_digital <= rst_req_wr & mgmt_writedata[2];  // rx pcs only
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (mgmt_address)
      ADDR_STATUS:
        rdata_common = {{(MGMT_DATA_W-3){1'b0}}, rx_ready, tx_ready, pll_locked};
      ADDR_RX_LOCK:  // ref lock low byte, data lock next byte
        rdata_common = {{(MGMT_DATA_W-8-LANES){1'b0}}, rx_is_lockedtodata,
                        {(8-LANES){1'b0}}, rx_is_lockedtoref};
      ADDR_RESET_REQ:  rdata_common = '0;  // requests never read back
      ADDR_LOOPBACK:   rdata_common = {{LANE_PAD{1'b0}}, rx_seriallpbken};
      ADDR_LOCKTOREF:  rdata_common = {{LANE_PAD{1'b0}}, rx_set_locktoref};
      ADDR_LOCKTODATA: rdata_common = {{LANE_PAD{1'b0}}, rx_set_locktodata};
      default:         rdata_common = '1;  // not ours, neutral for the and
    endcase
  end

endmodule

`default_nettype wire

// File: hw/mgmt_csr_pcs.sv
/* PCS register block; transmit polarity inversion and sticky 8b/10b error
   and disparity flags per lane, cleared by writing ones */
`timescale 1ns/10ps
`default_nettype none

module mgmt_csr_pcs (
  input  wire                            phy_mgmt_clk,
  input  wire                            arst_n,
  input  wire xcvr_mgmt_pkg::mgmt_addr_t mgmt_address,
  input  wire                            mgmt_write,
  input  wire xcvr_mgmt_pkg::mgmt_data_t mgmt_writedata,
  input  wire xcvr_mgmt_pkg::lane_vec_t  rx_errdetect,
  input  wire xcvr_mgmt_pkg::lane_vec_t  rx_disperr,
  output xcvr_mgmt_pkg::mgmt_data_t      rdata_pcs,
  output xcvr_mgmt_pkg::lane_vec_t       tx_invpolarity
);
  import xcvr_mgmt_pkg::*;

  lane_vec_t err_sticky;   // 8b/10b code errors seen
  lane_vec_t disp_sticky;  // disparity errors seen
  lane_vec_t err_clr;      // write-one-to-clear masks
  lane_vec_t disp_clr;
  logic      err_wr;

  assign err_wr   = mgmt_write && (mgmt_address == ADDR_PCS_ERR);
  assign err_clr  = err_wr ? mgmt_writedata[LANES-1:0] : '0;
  assign disp_clr = err_wr ? mgmt_writedata[8 +: LANES] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // polarity and sticky flags
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_invpolarity <= '0;
    end else if (mgmt_write && (mgmt_address == ADDR_TX_INVPOL)) begin
      tx_invpolarity <= mgmt_writedata[LANES-1:0];
    end
  end

  // new errors are ORed in after the clear, so a set wins over a clear
  always_ff @(posedge phy_mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      err_sticky  <= '0;
      disp_sticky <= '0;
    end else begin
      err_sticky  <= (err_sticky  & ~err_clr)  | rx_errdetect;
      disp_sticky <= (disp_sticky & ~disp_clr) | rx_disperr;
    end
  end

  // read mux, all ones outside the pcs addresses
  always_comb begin
    case (mgmt_address)
      ADDR_PCS_ERR:
        rdata_pcs = {{(MGMT_DATA_W-8-LANES){1'b0}}, disp_sticky,
                     {(8-LANES){1'b0}}, err_sticky};
      ADDR_TX_INVPOL:
        rdata_pcs = {{(MGMT_DATA_W-LANES){1'b0}}, tx_invpolarity};
      default:
        rdata_pcs = '1;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/mgmt_read_port.sv
/* management read port; merges the read data of both register blocks and
   stretches every read to one wait cycle through waitrequest */
`timescale 1ns/10ps
`default_nettype none

module mgmt_read_port (
  input  wire                            phy_mgmt_clk,
  input  wire                            arst_n,
  input  wire                            mgmt_read,
  input  wire xcvr_mgmt_pkg::mgmt_data_t rdata_common,
  input  wire xcvr_mgmt_pkg::mgmt_data_t rdata_pcs,
  output xcvr_mgmt_pkg::mgmt_data_t      mgmt_readdata,
  output logic                           mgmt_waitrequest
);
  import xcvr_mgmt_pkg::*;

  mgmt_data_t rdata_merged;  // blocks decode disjoint ranges
  logic       rd_phase;      // high in the cycle the read completes

  assign rdata_merged = rdata_common & rdata_pcs;

  // first cycle of a read stalls, second one delivers
  assign mgmt_waitrequest = mgmt_read & ~rd_phase;

  always_ff @(posedge phy_mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_phase <= 1'b0;
    end else begin
      rd_phase <= mgmt_read & ~rd_phase;  // drops after the data cycle
    end
  end

  // capture at the end of the wait cycle, address is held stable there
  always_ff @(posedge phy_mgmt_clk) begin
    if (mgmt_waitrequest) begin
      mgmt_readdata <= rdata_merged;
    end
  end

endmodule

`default_nettype wire

// File: hw/xcvr_reset_seq.sv
/* transceiver reset sequencer; synchronizes the lock flags and steps the tx
   and rx reset phases on timers, with restarts requested from the csr */
`timescale 1ns/10ps
`default_nettype none

module xcvr_reset_seq (
  input  wire                           phy_mgmt_clk,
  input  wire                           arst_n,
  input  wire                           pll_locked,
  input  wire xcvr_mgmt_pkg::lane_vec_t rx_is_lockedtoref,
  input  wire                           req_reset_all,
  input  wire                           req_tx_digital,
  input  wire                           req_rx_digital,
  output logic                          pll_powerdown,
  output xcvr_mgmt_pkg::lane_vec_t      tx_digitalreset,
  output xcvr_mgmt_pkg::lane_vec_t      rx_analogreset,
  output xcvr_mgmt_pkg::lane_vec_t      rx_digitalreset,
  output logic                          tx_ready,
  output logic                          rx_ready
);
  import xcvr_mgmt_pkg::*;

  logic [LANES:0] lock_meta;   // {pll, rx lanes}, first stage
  logic [LANES:0] lock_sync;
  logic           pll_lock_s;
  logic           rx_lock_all_s;  // every lane locked to ref
  tx_rst_state_t  tx_state;
  rx_rst_state_t  rx_state;
  rst_timer_t     tx_timer;
  rst_timer_t     rx_timer;

  ////////////////////////////////////////////////////////////////////////////
  // lock synchronizer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      lock_meta <= '0;
      lock_sync <= '0;
    end else begin
      lock_meta <= {pll_locked, rx_is_lockedtoref};
      lock_sync <= lock_meta;
    end
  end

  assign pll_lock_s    = lock_sync[LANES];
  assign rx_lock_all_s = &lock_sync[LANES-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // tx side: pll powerdown, wait for lock, hold pcs reset, ready
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_state <= TX_PLL_PD;
      tx_timer <= '0;
    end else if (req_reset_all) begin  // full restart
      tx_state <= TX_PLL_PD;
      tx_timer <= '0;
    end else if (req_tx_digital && (tx_state == TX_DIG_RST || tx_state == TX_READY)) begin
      tx_state <= TX_DIG_RST;  // only the pcs phase again
      tx_timer <= '0;
    end else begin
      case (tx_state)
        TX_PLL_PD: begin
          if (tx_timer == rst_timer_t'(T_PLL_POWERDOWN - 1)) begin
            tx_state <= TX_WAIT_LOCK;
            tx_timer <= '0;
          end else begin
            tx_timer <= tx_timer + 1'b1;
          end
        end
        TX_WAIT_LOCK: begin
          if (pll_lock_s) tx_state <= TX_DIG_RST;
          tx_timer <= '0;
        end
        TX_DIG_RST: begin
          if (!pll_lock_s) begin
            tx_state <= TX_WAIT_LOCK;  // lock lost mid-count
          end else if (tx_timer == rst_timer_t'(T_TX_DIGITALRESET - 1)) begin
            tx_state <= TX_READY;
          end else begin
            tx_timer <= tx_timer + 1'b1;
          end
        end
        TX_READY: if (!pll_lock_s) tx_state <= TX_WAIT_LOCK;
        default:  tx_state <= TX_PLL_PD;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // rx side: analog reset, wait for ref lock, hold pcs reset, ready
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge phy_mgmt_clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_state <= RX_ANA_RST;
      rx_timer <= '0;
    end else if (req_reset_all) begin
      rx_state <= RX_ANA_RST;
      rx_timer <= '0;
    end else if (req_rx_digital && (rx_state == RX_DIG_RST || rx_state == RX_READY)) begin
      rx_state <= RX_DIG_RST;
      rx_timer <= '0;
    end else begin
      case (rx_state)
        RX_ANA_RST: begin
          if (rx_timer == rst_timer_t'(T_RX_ANALOGRESET - 1)) begin
            rx_state <= RX_WAIT_LOCK;
            rx_timer <= '0;
          end else begin
            rx_timer <= rx_timer + 1'b1;
          end
        end
        RX_WAIT_LOCK: begin
          if (rx_lock_all_s) rx_state <= RX_DIG_RST;
          rx_timer <= '0;
        end
        RX_DIG_RST: begin
          if (!rx_lock_all_s) begin
            rx_state <= RX_WAIT_LOCK;
          end else if (rx_timer == rst_timer_t'(T_RX_DIGITALRESET - 1)) begin
            rx_state <= RX_READY;
          end else begin
            rx_timer <= rx_timer + 1'b1;
          end
        end
        RX_READY: if (!rx_lock_all_s) rx_state <= RX_WAIT_LOCK;
        default:  rx_state <= RX_ANA_RST;
      endcase
    end
  end

  // reset outputs decode straight from state, shared by all lanes
  assign pll_powerdown   = (tx_state == TX_PLL_PD);
  assign tx_digitalreset = {LANES{tx_state != TX_READY}};
  assign tx_ready        = (tx_state == TX_READY);
  assign rx_analogreset  = {LANES{rx_state == RX_ANA_RST}};
  assign rx_digitalreset = {LANES{rx_state != RX_READY}};  // also covers analog phase
  assign rx_ready        = (rx_state == RX_READY);

endmodule

`default_nettype wire

// File: hw/xcvr_mgmt_top.sv
/* management side of the PIPE transceiver wrapper; connects the register
   blocks, the read port and the reset sequencer to the PHY status pins */
`timescale 1ns/10ps
`default_nettype none

module xcvr_mgmt_top (
  input  wire                            phy_mgmt_clk,
  input  wire                            arst_n,
  // management slave
  input  wire xcvr_mgmt_pkg::mgmt_addr_t mgmt_address,
  input  wire                            mgmt_read,
  input  wire                            mgmt_write,
  input  wire xcvr_mgmt_pkg::mgmt_data_t mgmt_writedata,
  output wire xcvr_mgmt_pkg::mgmt_data_t mgmt_readdata,
  output wire                            mgmt_waitrequest,
  // status from the transceiver hard block
  input  wire                            pll_locked,
  input  wire xcvr_mgmt_pkg::lane_vec_t  rx_is_lockedtoref,
  input  wire xcvr_mgmt_pkg::lane_vec_t  rx_is_lockedtodata,
  input  wire xcvr_mgmt_pkg::lane_vec_t  rx_errdetect,
  input  wire xcvr_mgmt_pkg::lane_vec_t  rx_disperr,
  // resets and controls to the hard block
  output wire                            pll_powerdown,
  output wire xcvr_mgmt_pkg::lane_vec_t  tx_digitalreset,
  output wire xcvr_mgmt_pkg::lane_vec_t  rx_analogreset,
  output wire xcvr_mgmt_pkg::lane_vec_t  rx_digitalreset,
  output wire xcvr_mgmt_pkg::lane_vec_t  rx_seriallpbken,
  output wire xcvr_mgmt_pkg::lane_vec_t  rx_set_locktoref,
  output wire xcvr_mgmt_pkg::lane_vec_t  rx_set_locktodata,
  output wire xcvr_mgmt_pkg::lane_vec_t  tx_invpolarity,
  output wire                            tx_ready,
  output wire                            rx_ready
);
  import xcvr_mgmt_pkg::*;

  mgmt_data_t rdata_common;  // all ones outside the common map
  mgmt_data_t rdata_pcs;     // all ones outside the pcs map
  logic       req_reset_all;   // csr pulses into the sequencer
  logic       req_tx_digital;
  logic       req_rx_digital;

  mgmt_csr_common u_csr_common (
    .phy_mgmt_clk, .arst_n, .mgmt_address, .mgmt_write, .mgmt_writedata,
    .pll_locked, .rx_is_lockedtoref, .rx_is_lockedtodata, .tx_ready, .rx_ready,
    .rdata_common, .req_reset_all, .req_tx_digital, .req_rx_digital,
    .rx_seriallpbken, .rx_set_locktoref, .rx_set_locktodata
  );

  mgmt_csr_pcs u_csr_pcs (
    .phy_mgmt_clk, .arst_n, .mgmt_address, .mgmt_write, .mgmt_writedata,
    .rx_errdetect, .rx_disperr, .rdata_pcs, .tx_invpolarity
  );

  mgmt_read_port u_read_port (
    .phy_mgmt_clk, .arst_n, .mgmt_read, .rdata_common, .rdata_pcs,
    .mgmt_readdata, .mgmt_waitrequest
  );

  xcvr_reset_seq u_reset_seq (
    .phy_mgmt_clk, .arst_n, .pll_locked, .rx_is_lockedtoref,
    .req_reset_all, .req_tx_digital, .req_rx_digital,
    .pll_powerdown, .tx_digitalreset, .rx_analogreset, .rx_digitalreset,
    .tx_ready, .rx_ready
  );

endmodule

`default_nettype wire

// File: bench/xcvr_mgmt_props.sv
/* reset sequencer assertions; bound into every xcvr_reset_seq instance to
   watch the reset ordering and the csr request strobes */
`timescale 1ns/10ps
`default_nettype none

module xcvr_mgmt_props (
  input wire                           phy_mgmt_clk,
  input wire                           arst_n,
  input wire                           pll_powerdown,
  input wire                           tx_ready,
  input wire xcvr_mgmt_pkg::lane_vec_t rx_analogreset,
  input wire xcvr_mgmt_pkg::lane_vec_t rx_digitalreset,
  input wire                           req_reset_all,
  input wire                           req_tx_digital,
  input wire                           req_rx_digital
);
  import xcvr_mgmt_pkg::*;

  // ready only after the pll has been out of powerdown for the pcs reset period
  tx_ready_rise: assert property (@(posedge phy_mgmt_clk) disable iff (!arst_n)
    $rose(tx_ready) |-> !$past(pll_powerdown, T_TX_DIGITALRESET))
    else $error("tx_ready rose too soon after pll powerdown");

  // pcs released only once the analog side has been out of reset for the full period
  rx_reset_order: assert property (@(posedge phy_mgmt_clk) disable iff (!arst_n)
    $fell(&rx_digitalreset) |-> !(|$past(rx_analogreset, T_RX_DIGITALRESET)))
    else $error("rx pcs released early");

  // csr requests are single-cycle strobes
  req_all_pulse: assert property (@(posedge phy_mgmt_clk) disable iff (!arst_n)
    req_reset_all |=> !req_reset_all) else $error("req_reset_all held");
  req_tx_pulse: assert property (@(posedge phy_mgmt_clk) disable iff (!arst_n)
    req_tx_digital |=> !req_tx_digital) else $error("req_tx_digital held");
  req_rx_pulse: assert property (@(posedge phy_mgmt_clk) disable iff (!arst_n)
    req_rx_digital |=> !req_rx_digital) else $error("req_rx_digital held");

endmodule

bind xcvr_reset_seq xcvr_mgmt_props u_props (
  .phy_mgmt_clk, .arst_n, .pll_powerdown, .tx_ready, .rx_analogreset,
  .rx_digitalreset, .req_reset_all, .req_tx_digital, .req_rx_digital
);

`default_nettype wire

// File: bench/tb_xcvr_mgmt.sv
/* directed testbench for the transceiver management top; a PHY model
   answers the resets with lock flags, tasks drive the management bus */
`timescale 1ns/10ps
`default_nettype none

module tb_xcvr_mgmt;
  import xcvr_mgmt_pkg::*;

  localparam int        WAIT_LIMIT = 400;       // cycles before any wait gives up
  localparam lane_vec_t DATA_LOCK  = 4'b1011;   // model's lock-to-data lanes

  logic       phy_mgmt_clk = 1'b0;
  logic       arst_n;
  mgmt_addr_t mgmt_address;
  logic       mgmt_read;
  logic       mgmt_write;
  mgmt_data_t mgmt_writedata;
  mgmt_data_t mgmt_readdata;
  logic       mgmt_waitrequest;
  logic       pll_locked;
  logic       pll_powerdown;
  logic       tx_ready;
  logic       rx_ready;
  lane_vec_t  rx_is_lockedtoref;
  lane_vec_t  rx_is_lockedtodata;
  lane_vec_t  rx_errdetect;
  lane_vec_t  rx_disperr;
  lane_vec_t  tx_digitalreset;
  lane_vec_t  rx_analogreset;
  lane_vec_t  rx_digitalreset;
  lane_vec_t  rx_seriallpbken;
  lane_vec_t  rx_set_locktoref;
  lane_vec_t  rx_set_locktodata;
  lane_vec_t  tx_invpolarity;
  integer     seed = 32'h043941bf;
  int         errors = 0;      // value mismatches
  int         timeouts = 0;
  int         pll_wait = -1;   // -1 until a lock delay is drawn
  int         ref_wait = -1;
  string      test_name;
  mgmt_data_t rdata;
  int         rd_waits;

  xcvr_mgmt_top UUT (.*);

  always #2 phy_mgmt_clk = ~phy_mgmt_clk;  // 4 ns period

  ////////////////////////////////////////////////////////////////////////////
  // PHY model that raises the locks 5 to 20 cycles after the resets drop
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge phy_mgmt_clk) begin
    #1;
    if (pll_powerdown) begin
      pll_locked = 1'b0;  // no lock while powered down
      pll_wait   = -1;
    end else if (pll_wait < 0) begin
      pll_wait = 4 + {$random(seed)} % 16;
    end else if (pll_wait > 0) begin
      pll_wait--;
    end else begin
      pll_locked = 1'b1;
    end
    if (rx_analogreset[0]) begin
      rx_is_lockedtoref  = '0;
      rx_is_lockedtodata = '0;
      ref_wait           = -1;
    end else if (ref_wait < 0) begin
      ref_wait = 4 + {$random(seed)} % 16;
    end else if (ref_wait > 0) begin
      ref_wait--;
    end else begin
      rx_is_lockedtoref  = '1;         // all lanes together
      rx_is_lockedtodata = DATA_LOCK;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks and compares entered and left 1 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic mgmt_write_reg(input mgmt_addr_t addr, input mgmt_data_t data);
    mgmt_address   = addr;
    mgmt_writedata = data;
    mgmt_write     = 1'b1;
    @(posedge phy_mgmt_clk);  // register takes it here
    #1;
    mgmt_write = 1'b0;
  endtask

  task automatic mgmt_read_reg(input mgmt_addr_t addr, output mgmt_data_t data,
                               output int waits);
    mgmt_address = addr;
    mgmt_read    = 1'b1;
    #1;
    waits = mgmt_waitrequest;  // first cycle is a stall
    @(posedge phy_mgmt_clk);
    #1;
    while (mgmt_waitrequest && waits < WAIT_LIMIT) begin
      waits++;
      @(posedge phy_mgmt_clk);
      #1;
    end
    if (mgmt_waitrequest) begin
      timeouts++;
      $display("%s: read of address %h never completed", test_name, addr);
    end
    data      = mgmt_readdata;
    mgmt_read = 1'b0;
  endtask

  task automatic wait_for_ready(input bit rx_side);
    int n = 0;
    while (!(rx_side ? rx_ready : tx_ready) && n < WAIT_LIMIT) begin
      @(posedge phy_mgmt_clk);
      #1;
      n++;
    end
    if (!(rx_side ? rx_ready : tx_ready)) begin
      timeouts++;
      $display("%s: timed out waiting for %s", test_name, rx_side ? "rx_ready" : "tx_ready");
    end
  endtask

  task automatic check_data(input string what, input mgmt_data_t exp, input mgmt_data_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_lanes(input string what, input lane_vec_t exp, input lane_vec_t act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////
  task automatic power_up_sequence();
    test_name = "power_up";
    check_bit("pll_powerdown after reset", 1'b1, pll_powerdown);
    check_bit("waitrequest after reset", 1'b0, mgmt_waitrequest);
    wait_for_ready(1'b0);
    wait_for_ready(1'b1);
    check_bit("pll_powerdown", 1'b0, pll_powerdown);
    check_lanes("tx_digitalreset", '0, tx_digitalreset);
    check_lanes("rx_analogreset", '0, rx_analogreset);
    check_lanes("rx_digitalreset", '0, rx_digitalreset);
    mgmt_read_reg(ADDR_STATUS, rdata, rd_waits);
    check_data("status", 32'h7, rdata);  // pll lock, tx and rx ready
  endtask

  task automatic register_readback();
    mgmt_addr_t addrs [4] = '{ADDR_LOOPBACK, ADDR_LOCKTOREF, ADDR_LOCKTODATA, ADDR_TX_INVPOL};
    lane_vec_t  pat;
    lane_vec_t  out;
    test_name = "readback";
    foreach (addrs[i]) begin
      pat = lane_vec_t'($random(seed));
      mgmt_write_reg(addrs[i], mgmt_data_t'(pat));
      mgmt_read_reg(addrs[i], rdata, rd_waits);
      check_data($sformatf("reg %h", addrs[i]), mgmt_data_t'(pat), rdata);
      case (addrs[i])
        ADDR_LOOPBACK:   out = rx_seriallpbken;
        ADDR_LOCKTOREF:  out = rx_set_locktoref;
        ADDR_LOCKTODATA: out = rx_set_locktodata;
        default:         out = tx_invpolarity;
      endcase
      check_lanes($sformatf("pins of %h", addrs[i]), pat, out);
    end
  endtask

  task automatic undecoded_read();
    test_name = "undecoded";
    mgmt_read_reg(8'h10, rdata, rd_waits);
    check_data("addr 10", '1, rdata);  // neither block claims it
    check_bit("one wait cycle", 1'b1, rd_waits == 1);
    @(posedge phy_mgmt_clk);  // bus idle for a cycle
    #1;
    check_bit("idle waitrequest", 1'b0, mgmt_waitrequest);
  endtask

  task automatic sticky_flags();
    lane_vec_t  err_lanes  = 4'b0101;
    lane_vec_t  disp_lanes = 4'b1100;
    mgmt_data_t flags;
    test_name      = "sticky";
    flags          = {20'h0, disp_lanes, 4'h0, err_lanes};
    rx_errdetect   = err_lanes;  // one-cycle error pulses
    rx_disperr     = disp_lanes;
    @(posedge phy_mgmt_clk);
    #1;
    rx_errdetect = '0;
    rx_disperr   = '0;
    mgmt_read_reg(ADDR_PCS_ERR, rdata, rd_waits);
    check_data("flags set", flags, rdata);
    mgmt_write_reg(ADDR_PCS_ERR, flags);  // write ones back to clear
    mgmt_read_reg(ADDR_PCS_ERR, rdata, rd_waits);
    check_data("flags cleared", '0, rdata);
  endtask

  task automatic full_reset();
    test_name = "full_reset";
    mgmt_write_reg(ADDR_RESET_REQ, 32'h1);
    @(posedge phy_mgmt_clk);  // request reaches the sequencer
    #1;
    check_bit("tx_ready", 1'b0, tx_ready);
    check_bit("rx_ready", 1'b0, rx_ready);
    check_bit("pll_powerdown", 1'b1, pll_powerdown);
    wait_for_ready(1'b0);
    wait_for_ready(1'b1);
    mgmt_read_reg(ADDR_RX_LOCK, rdata, rd_waits);
    check_data("rx lock", {20'h0, DATA_LOCK, 4'h0, 4'hf}, rdata);  // model locks all ref lanes
  endtask

  task automatic rx_digital_reset();
    test_name = "rx_digital";
    mgmt_write_reg(ADDR_RESET_REQ, 32'h4);
    @(posedge phy_mgmt_clk);
    #1;
    check_bit("rx_ready", 1'b0, rx_ready);
    check_lanes("rx_digitalreset", '1, rx_digitalreset);
    check_bit("tx_ready", 1'b1, tx_ready);  // tx side untouched
    wait_for_ready(1'b1);
    check_bit("tx_ready after", 1'b1, tx_ready);
  endtask

  initial begin
    arst_n             = 1'b1;
    mgmt_address       = '0;
    mgmt_read          = 1'b0;
    mgmt_write         = 1'b0;
    mgmt_writedata     = '0;
    pll_locked         = 1'b0;
    rx_is_lockedtoref  = '0;
    rx_is_lockedtodata = '0;
    rx_errdetect       = '0;
    rx_disperr         = '0;
    #1;
    arst_n = 1'b0;
    repeat (16) @(posedge phy_mgmt_clk);
    #1;
    arst_n = 1'b1;
    power_up_sequence();
    register_readback();
    undecoded_read();
    sticky_flags();
    full_reset();
    rx_digital_reset();
    $display("summary: %0d check errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/xcvr_mgmt_pkg.sv
hw/mgmt_csr_common.sv
hw/mgmt_csr_pcs.sv
hw/mgmt_read_port.sv
hw/xcvr_reset_seq.sv
hw/xcvr_mgmt_top.sv
bench/xcvr_mgmt_props.sv
bench/tb_xcvr_mgmt.sv
